/* Bender.yml */
package:
  name: rp_analog

export_include_dirs:
  - .

sources:
  - rp_pkg.sv
  - rp_linear.sv
  - rp_regs.sv
  - rp_adc_frontend.sv
  - rp_dac_backend.sv
  - rp_analog_top.sv
  - target: test
    files:
      - tb_rp_analog_top.sv

/* rp_adc_frontend.sv */
// One ADC channel, from raw code to calibrated sample
// Raw code is offset binary with negative slope
// Loop and raw paths both reach the output in 3 cycles
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_adc_frontend import rp_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic        [`RP_DW-1:0] adc_dat_i,
  input  logic                     loop_i,
  input  logic signed [`RP_DW-1:0] dac_cal_i,
  input  cal_t                     cal_i,
  output logic signed [`RP_DW-1:0] adc_dat_o
);

  logic signed [`RP_DW-1:0] adc_conv;
  logic signed [`RP_DW-1:0] adc_q;

  // MSB kept, lower bits inverted gives two's complement
  assign adc_conv = {adc_dat_i[`RP_DW-1], ~adc_dat_i[`RP_DW-2:0]};

  // Input register sits after the loop mux
  // so both sources see the same latency
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_q <= '0;
    end else begin
      adc_q <= loop_i ? dac_cal_i : adc_conv;
    end
  end

  // Calibration, 2 more cycles
  rp_linear u_linear (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (adc_q),
    .cal_i   (cal_i),
    .dat_o   (adc_dat_o)
  );

endmodule

/* rp_analog_top.sv */
// Analog path with two ADC and two DAC channels behind AXI4-Lite
// Single clock domain, the DAC also runs on adc_clk
// No back-pressure, samples flow every cycle
// adc_vld_o only marks the end of the startup after reset
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_analog_top import rp_pkg::*; (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  axil_req_t                             axil_req_i,
  output axil_rsp_t                             axil_rsp_o,
  input  logic        [`RP_CHN-1:0][`RP_DW-1:0] adc_dat_i,
  output logic signed [`RP_CHN-1:0][`RP_DW-1:0] adc_dat_o,
  output logic                                  adc_vld_o,
  output logic        [`RP_CHN-1:0][`RP_DW-1:0] dac_dat_o
);

  cfg_t                                  cfg;
  logic signed [`RP_CHN-1:0][`RP_DW-1:0] dac_cal;
  logic        [1:0]                     vld_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  rp_regs u_rp_regs (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .cfg_o      (cfg)
  );

  // Startup counter, saturates at 3
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_cnt <= '0;
    end else if (vld_cnt != 2'd3) begin
      vld_cnt <= vld_cnt + 2'd1;
    end
  end

  assign adc_vld_o = &vld_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Channels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn
    // DAC side
    rp_dac_backend u_dac (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .set_i     (cfg.set[i]),
      .cal_i     (cfg.dac[i]),
      .dac_cal_o (dac_cal[i]),
      .dac_dat_o (dac_dat_o[i])
    );

    // ADC side, loops back the DAC of the same index
    rp_adc_frontend u_adc (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .adc_dat_i (adc_dat_i[i]),
      .loop_i    (cfg.loop),
      .dac_cal_i (dac_cal[i]),
      .cal_i     (cfg.adc[i]),
      .adc_dat_o (adc_dat_o[i])
    );
  end

endmodule

/* rp_dac_backend.sv */
// One DAC channel, from setpoint to DAC code
// DAC code is offset binary with negative slope
// Setpoint to code is 3 cycles, calibrated value is ready after 2
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_dac_backend import rp_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic signed [`RP_DW-1:0] set_i,
  input  cal_t                     cal_i,
  output logic signed [`RP_DW-1:0] dac_cal_o,
  output logic        [`RP_DW-1:0] dac_dat_o
);

  // Code of a zero sample
  localparam logic [`RP_DW-1:0] DAC_ZERO = {1'b0, {(`RP_DW-1){1'b1}}};

  // Calibrated value, also feeds the digital loop
  rp_linear u_linear (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (set_i),
    .cal_i   (cal_i),
    .dat_o   (dac_cal_o)
  );

  // Output register
  // two's complement back to negative slope code
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= DAC_ZERO;
    end else begin
      dac_dat_o <= {dac_cal_o[`RP_DW-1], ~dac_cal_o[`RP_DW-2:0]};
    end
  end

endmodule

/* rp_linear.sv */
// Gain, offset and saturation for one 14-bit sample stream
// Latency is 2 cycles, no valid or ready
// The shift rounds toward minus infinity
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_linear import rp_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic signed [`RP_DW-1:0] dat_i,
  input  cal_t                     cal_i,
  output logic signed [`RP_DW-1:0] dat_o
);

  // Full product width, no precision lost in stage 1
  localparam int PW = `RP_DW + `RP_MW;
  localparam logic signed [PW-1:0] SAT_MAX = 2**(`RP_DW-1) - 1;
  localparam logic signed [PW-1:0] SAT_MIN = -(2**(`RP_DW-1));

  logic signed [PW-1:0]     prod_q;
  logic signed [PW-1:0]     sum_w;
  logic signed [`RP_DW-1:0] sat_w;

  // Stage 1, multiply
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= dat_i * $signed(cal_i.mul);
    end
  end

  // Back to sample scale, then offset
  assign sum_w = (prod_q >>> `RP_GAIN_SHIFT) + $signed(cal_i.sum);

  // Clamp to the 14-bit range
  always_comb begin
    if (sum_w > SAT_MAX) begin
      sat_w = SAT_MAX[`RP_DW-1:0];
    end else if (sum_w < SAT_MIN) begin
      sat_w = SAT_MIN[`RP_DW-1:0];
    end else begin
      sat_w = sum_w[`RP_DW-1:0];
    end
  end

  // Stage 2
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat_w;
    end
  end

endmodule

/* rp_macros.svh */
// Widths and constants for the analog path
// Gains are signed Q2.14, so RP_GAIN_ONE is unity gain
// RP_CHN sets both the ADC and DAC channel count
// AXI4-Lite responses use the standard two-bit encoding
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// Channels per direction
`define RP_CHN        2
// Sample width, ADC and DAC alike
`define RP_DW         14
// Gain width
`define RP_MW         16
// Product shift back to sample scale
`define RP_GAIN_SHIFT 14
`define RP_GAIN_ONE   16'h4000

// Register bus
`define RP_AXI_AW     8
`define RP_AXI_DW     32
`define RP_RESP_OKAY   2'b00
`define RP_RESP_SLVERR 2'b10

`endif

/* rp_pkg.sv */
// Shared types for the analog path and its register bus
// Offsets are matched on all address bits, so unaligned ones are unmapped
// cfg_t is driven only by the register block
`include "rp_macros.svh"

package rp_pkg;

  // One gain/offset pair
  typedef struct packed {
    logic signed [`RP_MW-1:0] mul;
    logic signed [`RP_DW-1:0] sum;
  } cal_t;

  // Everything the register block drives
  typedef struct packed {
    logic                                  loop;
    cal_t        [`RP_CHN-1:0]             adc;
    cal_t        [`RP_CHN-1:0]             dac;
    logic signed [`RP_CHN-1:0][`RP_DW-1:0] set;
  } cfg_t;

  // AXI4-Lite, master to slave
  typedef struct packed {
    logic [`RP_AXI_AW-1:0]   awaddr;
    logic                    awvalid;
    logic [`RP_AXI_DW-1:0]   wdata;
    logic [`RP_AXI_DW/8-1:0] wstrb;
    logic                    wvalid;
    logic                    bready;
    logic [`RP_AXI_AW-1:0]   araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

  // AXI4-Lite, slave to master
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  arready;
    logic [`RP_AXI_DW-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
  } axil_rsp_t;

  // Register map
  typedef enum logic [`RP_AXI_AW-1:0] {
    CTRL     = 8'h00,
    ADC0_MUL = 8'h10,
    ADC0_SUM = 8'h14,
    ADC1_MUL = 8'h18,
    ADC1_SUM = 8'h1C,
    DAC0_MUL = 8'h20,
    DAC0_SUM = 8'h24,
    DAC1_MUL = 8'h28,
    DAC1_SUM = 8'h2C,
    DAC0_SET = 8'h30,
    DAC1_SET = 8'h34
  } reg_addr_e;

  // Response channel state
  typedef enum logic {
    IDLE,
    RESP
  } axil_state_e;

endpackage

/* rp_regs.sv */
// AXI4-Lite slave for the analog path settings
// One write and one read may be outstanding, each with its own FSM
// Readback is sign-extended, writes take the low bits of the merged word
// Unmapped offsets answer SLVERR, read as 0 and are ignored on write
`timescale 1ns/1ps
`include "rp_macros.svh"

module rp_regs import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      top_rst,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output cfg_t      cfg_o
);

  axil_state_e           wr_state;
  axil_state_e           rd_state;
  logic                  wr_go;
  logic                  rd_go;
  logic                  wr_hit;
  logic                  rd_hit;
  logic [`RP_AXI_DW-1:0] wr_old;
  logic [`RP_AXI_DW-1:0] wr_new;
  logic [`RP_AXI_DW-1:0] rd_word;
  logic [1:0]            bresp_q;
  logic [1:0]            rresp_q;
  logic [`RP_AXI_DW-1:0] rdata_q;

  function automatic logic [`RP_AXI_DW-1:0] sext_dw(input logic [`RP_DW-1:0] v);
    return {{(`RP_AXI_DW-`RP_DW){v[`RP_DW-1]}}, v};
  endfunction

  function automatic logic [`RP_AXI_DW-1:0] sext_mw(input logic [`RP_MW-1:0] v);
    return {{(`RP_AXI_DW-`RP_MW){v[`RP_MW-1]}}, v};
  endfunction

  // Register value at an offset, returns the hit flag
  function automatic logic reg_read(input cfg_t c, input logic [`RP_AXI_AW-1:0] addr,
                                    output logic [`RP_AXI_DW-1:0] dat);
    logic hit;
    hit = 1'b1;
    dat = '0;
    case (reg_addr_e'(addr))
      CTRL:     dat = {{(`RP_AXI_DW-1){1'b0}}, c.loop};
      ADC0_MUL: dat = sext_mw(c.adc[0].mul);
      ADC0_SUM: dat = sext_dw(c.adc[0].sum);
      ADC1_MUL: dat = sext_mw(c.adc[1].mul);
      ADC1_SUM: dat = sext_dw(c.adc[1].sum);
      DAC0_MUL: dat = sext_mw(c.dac[0].mul);
      DAC0_SUM: dat = sext_dw(c.dac[0].sum);
      DAC1_MUL: dat = sext_mw(c.dac[1].mul);
      DAC1_SUM: dat = sext_dw(c.dac[1].sum);
      DAC0_SET: dat = sext_dw(c.set[0]);
      DAC1_SET: dat = sext_dw(c.set[1]);
      default:  hit = 1'b0;
    endcase
    return hit;
  endfunction

  // Byte lanes without strobe keep the current value
  function automatic logic [`RP_AXI_DW-1:0] strb_merge(input logic [`RP_AXI_DW-1:0] old_w,
                                                       input logic [`RP_AXI_DW-1:0] new_w,
                                                       input logic [`RP_AXI_DW/8-1:0] strb);
    logic [`RP_AXI_DW-1:0] res;
    res = old_w;
    for (int b = 0; b < `RP_AXI_DW/8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Address and data must arrive together
  assign wr_go = (wr_state == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_go = (rd_state == IDLE) && axil_req_i.arvalid;

  always_comb begin
    wr_hit = reg_read(cfg_o, axil_req_i.awaddr, wr_old);
    rd_hit = reg_read(cfg_o, axil_req_i.araddr, rd_word);
  end

  assign wr_new = strb_merge(wr_old, axil_req_i.wdata, axil_req_i.wstrb);

  ////////////////////////////////////////////////////////////////////////////
  // Write channel and register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wr_state   <= IDLE;
      bresp_q    <= `RP_RESP_OKAY;
      cfg_o.loop <= 1'b0;
      // Unity gain, zero offset, zero setpoint
      for (int i = 0; i < `RP_CHN; i++) begin
        cfg_o.adc[i] <= '{mul: `RP_GAIN_ONE, sum: '0};
        cfg_o.dac[i] <= '{mul: `RP_GAIN_ONE, sum: '0};
        cfg_o.set[i] <= '0;
      end
    end else begin
      case (wr_state)
        IDLE: if (wr_go) begin
          wr_state <= RESP;
          bresp_q  <= wr_hit ? `RP_RESP_OKAY : `RP_RESP_SLVERR;
          // Register takes the new value in the next cycle
          case (reg_addr_e'(axil_req_i.awaddr))
            CTRL:     cfg_o.loop       <= wr_new[0];
            ADC0_MUL: cfg_o.adc[0].mul <= wr_new[`RP_MW-1:0];
            ADC0_SUM: cfg_o.adc[0].sum <= wr_new[`RP_DW-1:0];
            ADC1_MUL: cfg_o.adc[1].mul <= wr_new[`RP_MW-1:0];
            ADC1_SUM: cfg_o.adc[1].sum <= wr_new[`RP_DW-1:0];
            DAC0_MUL: cfg_o.dac[0].mul <= wr_new[`RP_MW-1:0];
            DAC0_SUM: cfg_o.dac[0].sum <= wr_new[`RP_DW-1:0];
            DAC1_MUL: cfg_o.dac[1].mul <= wr_new[`RP_MW-1:0];
            DAC1_SUM: cfg_o.dac[1].sum <= wr_new[`RP_DW-1:0];
            DAC0_SET: cfg_o.set[0]     <= wr_new[`RP_DW-1:0];
            DAC1_SET: cfg_o.set[1]     <= wr_new[`RP_DW-1:0];
            default:  ;
          endcase
        end
        RESP: if (axil_req_i.bready) begin
          wr_state <= IDLE;
        end
      endcase
    end
  end

  // Read channel, data captured at the address handshake
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rd_state <= IDLE;
      rdata_q  <= '0;
      rresp_q  <= `RP_RESP_OKAY;
    end else begin
      case (rd_state)
        IDLE: if (rd_go) begin
          rd_state <= RESP;
          rdata_q  <= rd_word;
          rresp_q  <= rd_hit ? `RP_RESP_OKAY : `RP_RESP_SLVERR;
        end
        RESP: if (axil_req_i.rready) begin
          rd_state <= IDLE;
        end
      endcase
    end
  end

  always_comb begin
    axil_rsp_o.awready = wr_go;
    axil_rsp_o.wready  = wr_go;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = (wr_state == RESP);
    axil_rsp_o.arready = rd_go;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = (rd_state == RESP);
  end

  // Write response is held until the master accepts it
  a_bvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

  // Read data and response stay frozen while waiting for rready
  a_rvalid_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    axil_rsp_o.rvalid && !axil_req_i.rready
    |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata) && $stable(axil_rsp_o.rresp));

endmodule

/* rp_stimulus.txt */
# name op addr/channel value expected, numbers in hex
# write: value=wdata expected=bresp, read: value=rresp expected=rdata, adcrnd: value=count
rst_ctrl       read   00 0        00000000
rst_adc0_mul   read   10 0        00004000
rst_adc0_sum   read   14 0        00000000
rst_adc1_mul   read   18 0        00004000
rst_adc1_sum   read   1c 0        00000000
rst_dac0_mul   read   20 0        00004000
rst_dac0_sum   read   24 0        00000000
rst_dac1_mul   read   28 0        00004000
rst_dac1_sum   read   2c 0        00000000
rst_dac0_set   read   30 0        00000000
rst_dac1_set   read   34 0        00000000
rst_dac0_code  dac    0  0        1fff
rst_dac1_code  dac    1  0        1fff
wr_ctrl        write  00 00000001 0
rd_ctrl        read   00 0        00000001
wr_ctrl_off    write  00 00000000 0
wr_dac1_set    write  34 00003ff0 0
rd_dac1_set    read   34 0        fffffff0
wr_dac0_mul    write  20 0000c000 0
rd_dac0_mul    read   20 0        ffffc000
wr_unmapped    write  3c ffffffff 2
rd_unmapped    read   3c 2        00000000
rd_unaligned   read   12 2        00000000
rd_kept_set    read   34 0        fffffff0
rd_kept_mul    read   20 0        ffffc000
adc_unity0     adcrnd 0  6        0
adc_unity1     adcrnd 1  6        0
adc_zero       adc    0  1fff     0000
adc_top        adc    0  0000     1fff
wr_adc0_mul    write  10 00002000 0
wr_adc0_sum    write  14 00000064 0
adc_half_pos   adc    0  0000     1063
adc_half_neg   adc    0  3fff     3064
adc_half_m1    adc    0  2000     0063
adc_cal0       adcrnd 0  6        0
wr_adc1_mul    write  18 00007fff 0
adc_sat_pos    adc    1  0000     1fff
adc_sat_neg    adc    1  3fff     2000
adc_gain2      adc    1  1c00     07fd
dac1_code      dac    1  0        200f
wr_dac0_set    write  30 00000100 0
dac0_neg_gain  dac    0  0        20ff
wr_dac0_sum    write  24 00000010 0
dac0_offset    dac    0  0        20ef
wr_dac1_mul    write  28 00007fff 0
wr_dac1_set2   write  34 00001800 0
dac1_sat       dac    1  0        0000
wr_loop_on     write  00 00000001 0
loop_adc0      adc    0  0000     3fec
loop_adc1      adc    1  1fff     1fff
wr_loop_off    write  00 00000000 0
raw_adc0       adc    0  2000     0063
raw_adc1       adc    1  1fff     0000

/* tb_rp_analog_top.sv */
// Self-checking testbench for the analog path top level
// Steps are read from rp_stimulus.txt, run from the project root
// Random ADC steps are checked against a model kept here
// That model follows only writes to the ADC gain/offset offsets
// All AXI writes use full byte strobes
`timescale 1ns/1ps
`include "rp_macros.svh"

module tb_rp_analog_top import rp_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int HS_LIMIT   = 16;
  // Cycles to wait after any change before a check
  localparam int SETTLE     = 8;

  logic                                  adc_clk;
  logic                                  top_rst;
  axil_req_t                             axil_req;
  axil_rsp_t                             axil_rsp;
  logic        [`RP_CHN-1:0][`RP_DW-1:0] adc_dat;
  logic signed [`RP_CHN-1:0][`RP_DW-1:0] adc_out;
  logic                                  adc_vld;
  logic        [`RP_CHN-1:0][`RP_DW-1:0] dac_out;

  string       step_name[$];
  string       step_op[$];
  logic [31:0] step_addr[$];
  logic [31:0] step_val[$];
  logic [31:0] step_exp[$];
  int          n_steps;
  int          n_checks;
  int          n_errors;
  int          adc_gain[`RP_CHN];
  int          adc_off[`RP_CHN];

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  rp_analog_top u_rp_analog_top (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .adc_dat_i  (adc_dat),
    .adc_dat_o  (adc_out),
    .adc_vld_o  (adc_vld),
    .dac_dat_o  (dac_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Raw code to calibrated sample
  function automatic logic [`RP_DW-1:0] adc_expect(input logic [`RP_DW-1:0] raw,
                                                   input int gain, input int off);
    longint x;
    longint y;
    // Negative slope, code 0 is positive full scale
    x = 8191 - longint'(raw);
    // Signed shift floors the scaled product
    y = (x * gain) >>> `RP_GAIN_SHIFT;
    y = y + off;
    if (y > 8191) begin
      y = 8191;
    end else if (y < -8192) begin
      y = -8192;
    end
    return y[`RP_DW-1:0];
  endfunction

  // Shadow of the ADC gain/offset registers
  task automatic track_adc_cal(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
      8'h10: adc_gain[0] = int'($signed(data[15:0]));
      8'h14: adc_off[0]  = int'($signed(data[13:0]));
      8'h18: adc_gain[1] = int'($signed(data[15:0]));
      8'h1c: adc_off[1]  = int'($signed(data[13:0]));
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_steps(output bit ok);
    int          fd;
    string       line;
    string       name;
    string       op;
    logic [31:0] addr;
    logic [31:0] val;
    logic [31:0] exp;
    ok = 1'b0;
    fd = $fopen("rp_stimulus.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comments and blank lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %s %h %h %h", name, op, addr, val, exp) == 5) begin
          step_name.push_back(name);
          step_op.push_back(op);
          step_addr.push_back(addr);
          step_val.push_back(val);
          step_exp.push_back(exp);
        end else begin
          n_errors++;
          $display("Stimulus line could not be parsed: %s", line);
        end
      end
    end
    $fclose(fd);
    ok = (step_name.size() > 0);
  endtask

  // bready is high from the start, ready sampled 1 ns after the drive
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp, output bit done);
    int cnt;
    done = 1'b0;
    resp = 2'b00;
    cnt  = 0;
    @(negedge adc_clk);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    #1;
    while (!(axil_rsp.awready && axil_rsp.wready) && cnt < HS_LIMIT) begin
      @(negedge adc_clk);
      #1;
      cnt++;
    end
    // Handshake on the next rising edge
    @(negedge adc_clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid && cnt < HS_LIMIT) begin
      @(negedge adc_clk);
      cnt++;
    end
    if (cnt < HS_LIMIT) begin
      resp = axil_rsp.bresp;
      done = 1'b1;
      @(negedge adc_clk);
    end
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [1:0] resp,
                           output logic [31:0] data, output bit done);
    int cnt;
    done = 1'b0;
    resp = 2'b00;
    data = '0;
    cnt  = 0;
    @(negedge adc_clk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    #1;
    while (!axil_rsp.arready && cnt < HS_LIMIT) begin
      @(negedge adc_clk);
      #1;
      cnt++;
    end
    @(negedge adc_clk);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid && cnt < HS_LIMIT) begin
      @(negedge adc_clk);
      cnt++;
    end
    if (cnt < HS_LIMIT) begin
      resp = axil_rsp.rresp;
      data = axil_rsp.rdata;
      done = 1'b1;
      @(negedge adc_clk);
    end
    axil_req.rready = 1'b0;
  endtask

  task automatic drive_adc(input int ch, input logic [`RP_DW-1:0] raw);
    @(negedge adc_clk);
    adc_dat[ch] = raw;
    repeat (SETTLE) @(negedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One stimulus step
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_step(input int i);
    logic [1:0]        resp;
    logic [31:0]       rdata;
    logic [31:0]       rnd;
    logic [`RP_DW-1:0] raw;
    logic [`RP_DW-1:0] exp;
    bit                done;
    int                ch;
    ch = int'(step_addr[i][0]);
    if (step_op[i] == "write") begin
      axil_write(step_addr[i][7:0], step_val[i], resp, done);
      track_adc_cal(step_addr[i][7:0], step_val[i]);
      n_checks++;
      if (!done) begin
        n_errors++;
        $display("No write response from the DUT in step %s", step_name[i]);
      end else if (resp !== step_exp[i][1:0]) begin
        n_errors++;
        $display("ERROR %s bresp: expected %h, actual %h", step_name[i], step_exp[i][1:0], resp);
      end
    end else if (step_op[i] == "read") begin
      axil_read(step_addr[i][7:0], resp, rdata, done);
      n_checks += 2;
      if (!done) begin
        n_errors++;
        $display("No read data from the DUT in step %s", step_name[i]);
      end else begin
        if (resp !== step_val[i][1:0]) begin
          n_errors++;
          $display("ERROR %s rresp: expected %h, actual %h", step_name[i], step_val[i][1:0], resp);
        end
        if (rdata !== step_exp[i]) begin
          n_errors++;
          $display("ERROR %s rdata: expected %h, actual %h", step_name[i], step_exp[i], rdata);
        end
      end
    end else if (step_op[i] == "adc") begin
      drive_adc(ch, step_val[i][`RP_DW-1:0]);
      n_checks++;
      if (adc_out[ch] !== step_exp[i][`RP_DW-1:0]) begin
        n_errors++;
        $display("ERROR %s: expected %h, actual %h", step_name[i], step_exp[i][`RP_DW-1:0],
                 adc_out[ch]);
      end
    end else if (step_op[i] == "adcrnd") begin
      for (int k = 0; k < int'(step_val[i]); k++) begin
        rnd = $urandom();
        raw = rnd[`RP_DW-1:0];
        exp = adc_expect(raw, adc_gain[ch], adc_off[ch]);
        drive_adc(ch, raw);
        n_checks++;
        if (adc_out[ch] !== exp) begin
          n_errors++;
          $display("ERROR %s raw %h: expected %h, actual %h", step_name[i], raw, exp, adc_out[ch]);
        end
      end
    end else if (step_op[i] == "dac") begin
      repeat (SETTLE) @(negedge adc_clk);
      n_checks++;
      if (dac_out[ch] !== step_exp[i][`RP_DW-1:0]) begin
        n_errors++;
        $display("ERROR %s: expected %h, actual %h", step_name[i], step_exp[i][`RP_DW-1:0],
                 dac_out[ch]);
      end
    end else begin
      n_errors++;
      $display("Unknown operation %s in step %s", step_op[i], step_name[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit loaded;
    top_rst  = 1'b1;
    axil_req = '0;
    adc_dat  = '0;
    n_steps  = 0;
    n_checks = 0;
    n_errors = 0;
    for (int c = 0; c < `RP_CHN; c++) begin
      adc_gain[c] = 16384;
      adc_off[c]  = 0;
    end
    // Fixed seed for the random ADC codes
    void'($urandom(32'h9083));
    load_steps(loaded);
    if (!loaded) begin
      n_errors++;
      $display("No steps could be read from rp_stimulus.txt");
    end else begin
      n_steps = step_name.size();
      repeat (2) @(posedge adc_clk);
      @(negedge adc_clk);
      n_checks++;
      if (adc_vld !== 1'b0) begin
        n_errors++;
        $display("ERROR reset_vld_low: expected %b, actual %b", 1'b0, adc_vld);
      end
      top_rst = 1'b0;
      repeat (SETTLE) @(negedge adc_clk);
      n_checks++;
      if (adc_vld !== 1'b1) begin
        n_errors++;
        $display("ERROR reset_vld_high: expected %b, actual %b", 1'b1, adc_vld);
      end
      for (int i = 0; i < n_steps; i++) begin
        run_step(i);
      end
    end
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Budget of 40 cycles per step
  initial begin
    wait (n_steps > 0);
    #(n_steps * 40 * CLK_PERIOD);
    $display("The run timed out after %0d steps' worth of cycles", n_steps);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
rp_pkg.sv
rp_linear.sv
rp_regs.sv
rp_adc_frontend.sv
rp_dac_backend.sv
rp_analog_top.sv
tb_rp_analog_top.sv
